/* rtl/eth_rx_defs.svh */
`ifndef ETH_RX_DEFS_SVH
`define ETH_RX_DEFS_SVH

// station address
// the first octet on the wire sits in bits 47:40
`define ETH_RX_STATION_MAC 48'h02_00_5e_4a_17_c3

// register value after a clean frame plus its FCS, no final inversion
`define ETH_RX_CRC_RESIDUE 32'hdebb20e3

// destination address, 6 octets
`define ETH_RX_ADDR_DIBITS 24

// dst + src + ethertype, 14 octets
`define ETH_RX_HEADER_DIBITS 56

// accepted frame counter
`define ETH_RX_COUNT_W 14

`endif

/* rtl/eth_rx_pkg.sv */
`default_nettype none

`include "eth_rx_defs.svh"

package eth_rx_pkg;

  // one rmii receive pair
  typedef logic [1:0]  dibit_t;
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] crc_t;
  typedef logic [`ETH_RX_COUNT_W-1:0] frame_count_t;

  // rmii_rx framing states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_PREAMBLE,
    RX_DATA
  } rx_state_t;

  // mac_filter states
  typedef enum logic [1:0] {
    FLT_ADDR,
    FLT_HEADER,
    FLT_PAYLOAD,
    FLT_DROP
  } filter_state_t;

endpackage

`default_nettype wire

/* rtl/rmii_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module rmii_rx import eth_rx_pkg::*; (
  input  wire logic   eth_refclk,
  input  wire logic   rst_n,
  input  wire dibit_t rxd,
  input  wire logic   crsdv,
  output dibit_t      wire_dibit,
  output logic        wire_valid
);

  localparam dibit_t pre_dibit = 2'b01;
  localparam dibit_t sfd_dibit = 2'b11;

  rx_state_t state;
  logic      crsdv_q;

  always_ff @(posedge eth_refclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      crsdv_q    <= 1'b0;
      wire_valid <= 1'b0;
    end else begin
      crsdv_q    <= crsdv;
      wire_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          // only a fresh carrier starts a hunt
          // a rejected burst sits here until crsdv drops
          if (crsdv && !crsdv_q) begin
            state <= RX_PREAMBLE;
          end
        end
        RX_PREAMBLE: begin
          if (!crsdv) begin
            state <= RX_IDLE;
          end else if (rxd == sfd_dibit) begin
            state <= RX_DATA;
          end else if (rxd != pre_dibit) begin
            // garbage in the preamble
            state <= RX_IDLE;
          end
        end
        RX_DATA: begin
          if (!crsdv) begin
            state <= RX_IDLE;
          end else begin
            wire_valid <= 1'b1;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // dibit capture, meaningful only with wire_valid
  always_ff @(posedge eth_refclk) begin
    if (state == RX_DATA) begin
      wire_dibit <= rxd;
    end
  end

endmodule

`default_nettype wire

/* rtl/bit_order.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_order import eth_rx_pkg::*; (
  input  wire logic   eth_refclk,
  input  wire logic   rst_n,
  input  wire dibit_t in_dibit,
  input  wire logic   in_valid,
  output dibit_t      out_dibit,
  output logic        out_valid
);

  // two four-entry banks, one collects while the other empties
  dibit_t grp_buf [2][4];
  logic       col_bank;
  logic [1:0] idx;
  logic       emt_full;
  logic       group_end;

  assign group_end = (idx == 2'd3);

  always_ff @(posedge eth_refclk or negedge rst_n) begin
    if (!rst_n) begin
      idx       <= 2'd0;
      col_bank  <= 1'b0;
      emt_full  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= emt_full;
      // keep stepping while a group drains after the frame ends
      if (in_valid || emt_full) begin
        idx <= idx + 2'd1;
      end else begin
        idx <= 2'd0;
      end
      if (group_end) begin
        // a partial last group never sets this
        emt_full <= in_valid;
        if (in_valid) begin
          col_bank <= ~col_bank;
        end
      end
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (in_valid) begin
      grp_buf[col_bank][idx] <= in_dibit;
    end
    // reversed read, dibit 3 holds bits 7:6
    out_dibit <= grp_buf[~col_bank][~idx];
  end

endmodule

`default_nettype wire

/* rtl/mac_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module mac_filter import eth_rx_pkg::*; (
  input  wire logic   eth_refclk,
  input  wire logic   rst_n,
  input  wire dibit_t ord_dibit,
  input  wire logic   ord_valid,
  output dibit_t      payload_dibit,
  output logic        payload_valid,
  output logic        frame_match
);

  localparam logic [5:0] addr_last = 6'(`ETH_RX_ADDR_DIBITS - 1);
  localparam logic [5:0] hdr_last  = 6'(`ETH_RX_HEADER_DIBITS - 1);

  filter_state_t state;
  mac_addr_t     addr_sr;
  mac_addr_t     addr_next;
  logic [5:0]    dibit_cnt;
  logic          addr_hit;

  // dibits arrive msb first so the shift builds the address in order
  assign addr_next = {addr_sr[45:0], ord_dibit};
  assign addr_hit  = (addr_next == `ETH_RX_STATION_MAC) || (addr_next == '1);

  always_ff @(posedge eth_refclk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= FLT_ADDR;
      dibit_cnt     <= 6'd0;
      frame_match   <= 1'b0;
      payload_valid <= 1'b0;
    end else begin
      payload_valid <= ord_valid && (state == FLT_PAYLOAD);
      if (!ord_valid) begin
        state     <= FLT_ADDR;
        dibit_cnt <= 6'd0;
      end else begin
        case (state)
          FLT_ADDR: begin
            dibit_cnt <= dibit_cnt + 6'd1;
            // previous frame's verdict held until now
            if (dibit_cnt == 6'd0) begin
              frame_match <= 1'b0;
            end
            if (dibit_cnt == addr_last) begin
              frame_match <= addr_hit;
              state       <= addr_hit ? FLT_HEADER : FLT_DROP;
            end
          end
          FLT_HEADER: begin
            // src address and ethertype are skipped
            dibit_cnt <= dibit_cnt + 6'd1;
            if (dibit_cnt == hdr_last) begin
              state <= FLT_PAYLOAD;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge eth_refclk) begin
    if (ord_valid && state == FLT_ADDR) begin
      addr_sr <= addr_next;
    end
    if (ord_valid && state == FLT_PAYLOAD) begin
      payload_dibit <= ord_dibit;
    end
  end

endmodule

`default_nettype wire

/* rtl/crc32_check.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module crc32_check import eth_rx_pkg::*; (
  input  wire logic   eth_refclk,
  input  wire logic   rst_n,
  input  wire dibit_t wire_dibit,
  input  wire logic   wire_valid,
  output logic        done,
  output logic        kill
);

  // reflected form of 0x04c11db7
  localparam crc_t crc_poly = 32'hedb88320;

  crc_t crc_reg;
  crc_t crc_seed;
  logic valid_q;

  // two serial steps, rxd[0] is the earlier bit on the wire
  function automatic crc_t crc_dibit(crc_t crc_in, dibit_t d);
    crc_t c;
    c = crc_in;
    for (int i = 0; i < 2; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ crc_poly;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // preset on the first dibit of a frame
  assign crc_seed = valid_q ? crc_reg : '1;

  always_ff @(posedge eth_refclk or negedge rst_n) begin
    if (!rst_n) begin
      crc_reg <= '1;
      valid_q <= 1'b0;
      done    <= 1'b0;
      kill    <= 1'b0;
    end else begin
      valid_q <= wire_valid;
      done    <= valid_q && !wire_valid;
      if (wire_valid) begin
        crc_reg <= crc_dibit(crc_seed, wire_dibit);
      end
      // fcs went through the register too, so a good frame lands on the residue
      if (valid_q && !wire_valid) begin
        kill <= (crc_reg != `ETH_RX_CRC_RESIDUE);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/eth_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top import eth_rx_pkg::*; (
  input  wire logic   eth_refclk,
  input  wire logic   rst_n,
  input  wire dibit_t rxd,
  input  wire logic   crsdv,
  output dibit_t      payload_dibit,
  output logic        payload_valid,
  output logic        done,
  output logic        kill,
  output frame_count_t frame_count
);

  // wire order stream, feeds the reorder and crc paths
  dibit_t wire_dibit;
  logic   wire_valid;
  // msb first per byte
  dibit_t ord_dibit;
  logic   ord_valid;
  logic   frame_match;

  rmii_rx u_rmii_rx (
    .eth_refclk (eth_refclk),
    .rst_n      (rst_n),
    .rxd        (rxd),
    .crsdv      (crsdv),
    .wire_dibit (wire_dibit),
    .wire_valid (wire_valid)
  );

  bit_order u_bit_order (
    .eth_refclk (eth_refclk),
    .rst_n      (rst_n),
    .in_dibit   (wire_dibit),
    .in_valid   (wire_valid),
    .out_dibit  (ord_dibit),
    .out_valid  (ord_valid)
  );

  mac_filter u_mac_filter (
    .eth_refclk    (eth_refclk),
    .rst_n         (rst_n),
    .ord_dibit     (ord_dibit),
    .ord_valid     (ord_valid),
    .payload_dibit (payload_dibit),
    .payload_valid (payload_valid),
    .frame_match   (frame_match)
  );

  crc32_check u_crc32_check (
    .eth_refclk (eth_refclk),
    .rst_n      (rst_n),
    .wire_dibit (wire_dibit),
    .wire_valid (wire_valid),
    .done       (done),
    .kill       (kill)
  );

  // frame_match still belongs to this frame when done fires
  always_ff @(posedge eth_refclk or negedge rst_n) begin
    if (!rst_n) begin
      frame_count <= '0;
    end else if (done && !kill && frame_match) begin
      frame_count <= frame_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sim/eth_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_defs.svh"

module eth_rx_tb import eth_rx_pkg::*; ();

  localparam int n_rows     = 8;
  localparam int wait_limit = 200;

  // one stimulus row
  typedef struct packed {
    mac_addr_t   dst;
    logic [15:0] len;
    logic        bad_fcs;
    logic        bad_pre;
    logic        accept;
  } row_t;

  logic         eth_refclk;
  logic         rst_n;
  dibit_t       rxd;
  logic         crsdv;
  dibit_t       payload_dibit;
  logic         payload_valid;
  logic         done;
  logic         kill;
  frame_count_t frame_count;

  row_t         rows [n_rows];
  integer       seed;
  int           errors;
  int           failed;
  int           done_total = 0;
  logic         kill_seen;
  frame_count_t exp_count;
  // octets in wire order, from preamble to fcs
  byte_t        wire_q [$];
  // payload dibits expected out, and those seen
  dibit_t       exp_q [$];
  dibit_t       got_q [$];

  eth_rx_top u_dut (
    .eth_refclk    (eth_refclk),
    .rst_n         (rst_n),
    .rxd           (rxd),
    .crsdv         (crsdv),
    .payload_dibit (payload_dibit),
    .payload_valid (payload_valid),
    .done          (done),
    .kill          (kill),
    .frame_count   (frame_count)
  );

  initial begin
    eth_refclk = 1'b0;
    forever #20 eth_refclk = ~eth_refclk;
  end

  // outputs sampled mid-cycle, away from the driving edge
  always @(negedge eth_refclk) begin
    if (payload_valid) got_q.push_back(payload_dibit);
    if (done) begin
      done_total = done_total + 1;
      kill_seen  = kill;
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dibit(input string name, input dibit_t got, input dibit_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input frame_count_t got,
                             input frame_count_t exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one octet through the reflected crc-32, lsb first
  function automatic crc_t crc_step(input crc_t c, input byte_t b);
    crc_t r;
    r = c ^ crc_t'(b);
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
    end
    return r;
  endfunction

  // builds one frame, fills the expected stream, then drives it on rxd
  task automatic send_frame(input row_t r, input logic fwd);
    logic [111:0] hdr;
    byte_t        b;
    crc_t         c;
    // dst, a fixed source, ipv4 ethertype
    hdr = {r.dst, 48'h02_11_22_33_44_55, 16'h0800};
    c   = '1;
    wire_q.delete();
    exp_q.delete();
    repeat (7) wire_q.push_back(8'h55);
    // broken preamble carries 00 where the delimiter belongs
    wire_q.push_back(r.bad_pre ? 8'h00 : 8'hd5);
    for (int i = 0; i < 14 + int'(r.len); i++) begin
      if (i < 14) begin
        b = hdr[111 - 8*i -: 8];
      end else begin
        b = byte_t'($random(seed));
      end
      c = crc_step(c, b);
      wire_q.push_back(b);
    end
    // fcs inverted, low octet first
    c = ~c;
    if (r.bad_fcs) c[13] = ~c[13];
    for (int i = 0; i < 4; i++) wire_q.push_back(c[8*i +: 8]);
    // payload and fcs come out msb dibit first
    if (fwd) begin
      for (int i = 22; i < wire_q.size(); i++) begin
        b = wire_q[i];
        for (int k = 3; k >= 0; k--) exp_q.push_back(b[2*k +: 2]);
      end
    end
    // rmii sends each octet lsb dibit first
    foreach (wire_q[i]) begin
      b = wire_q[i];
      for (int k = 0; k < 4; k++) begin
        @(posedge eth_refclk);
        rxd   <= b[2*k +: 2];
        crsdv <= 1'b1;
      end
    end
    @(posedge eth_refclk);
    crsdv <= 1'b0;
    rxd   <= '0;
    repeat (12) @(posedge eth_refclk);
  endtask

  initial begin
    row_t r;
    logic fwd;
    int   e0;
    int   d0;
    int   g0;
    int   n;
    rst_n     = 1'b0;
    rxd       = '0;
    crsdv     = 1'b0;
    seed      = 16091;
    errors    = 0;
    failed    = 0;
    exp_count = '0;
    // dst, payload octets, bad fcs, broken preamble, accept
    rows[0] = '{`ETH_RX_STATION_MAC, 16'd46, 1'b0, 1'b0, 1'b1};
    rows[1] = '{`ETH_RX_STATION_MAC, 16'd46, 1'b1, 1'b0, 1'b0};
    rows[2] = '{48'h02_00_5e_4a_17_c4, 16'd46, 1'b0, 1'b0, 1'b0};
    rows[3] = '{48'hff_ff_ff_ff_ff_ff, 16'd60, 1'b0, 1'b0, 1'b1};
    rows[4] = '{`ETH_RX_STATION_MAC, 16'd20, 1'b0, 1'b1, 1'b0};
    rows[5] = '{`ETH_RX_STATION_MAC, 16'd1, 1'b0, 1'b0, 1'b1};
    rows[6] = '{`ETH_RX_STATION_MAC, 16'd46, 1'b0, 1'b0, 1'b1};
    rows[7] = '{`ETH_RX_STATION_MAC, 16'd300, 1'b0, 1'b0, 1'b1};
    repeat (16) @(posedge eth_refclk);
    rst_n <= 1'b1;
    @(negedge eth_refclk);
    check_bit("payload_valid", payload_valid, 1'b0);
    check_bit("done", done, 1'b0);
    check_bit("kill", kill, 1'b0);
    check_count("frame_count", frame_count, '0);
    $display("test 0 reset: %s", errors == 0 ? "ok" : "failed");
    if (errors != 0) failed++;
    for (int t = 0; t < n_rows; t++) begin
      r   = rows[t];
      // filter passes own and broadcast addresses whatever the crc
      fwd = !r.bad_pre && (r.dst == `ETH_RX_STATION_MAC || r.dst == '1);
      e0  = errors;
      d0  = done_total;
      g0  = got_q.size();
      send_frame(r, fwd);
      // done follows carrier loss, none at all without a delimiter
      n = 0;
      while (done_total == d0 && n < wait_limit) begin
        @(posedge eth_refclk);
        n++;
      end
      if (r.bad_pre && done_total != d0) begin
        $display("done pulsed on a burst without a delimiter");
        errors++;
      end else if (!r.bad_pre && done_total != d0 + 1) begin
        $display("expected one done pulse, saw %0d before timeout", done_total - d0);
        errors++;
      end else if (!r.bad_pre) begin
        check_bit("kill", kill_seen, r.bad_fcs);
      end
      n = 0;
      while (got_q.size() - g0 < exp_q.size() && n < wait_limit) begin
        @(posedge eth_refclk);
        n++;
      end
      if (got_q.size() - g0 != exp_q.size()) begin
        $display("payload stream has %0d dibits where %0d were expected",
                 got_q.size() - g0, exp_q.size());
        errors++;
      end else begin
        foreach (exp_q[i]) check_dibit("payload_dibit", got_q[g0 + i], exp_q[i]);
      end
      // counter settles one cycle after done
      @(negedge eth_refclk);
      if (r.accept) exp_count = exp_count + frame_count_t'(1);
      check_count("frame_count", frame_count, exp_count);
      $display("test %0d dst %h len %0d: %s", t + 1, r.dst, r.len,
               errors == e0 ? "ok" : "failed");
      if (errors != e0) failed++;
    end
    $display("tests %0d, failed %0d, errors %0d", n_rows + 1, failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = eth_rx_tb
FILELIST  = eth_rx_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* eth_rx_top.f */
+incdir+rtl
rtl/eth_rx_pkg.sv
rtl/rmii_rx.sv
rtl/bit_order.sv
rtl/mac_filter.sv
rtl/crc32_check.sv
rtl/eth_rx_top.sv
sim/eth_rx_tb.sv
